/* opPkg.sv */
`default_nettype none

package opPkg;

	// Top-level operation class, issued on opCmd
	typedef enum logic [2:0] {
		NOP    = 3'd0,	// No effect, no write
		MOV_IR = 3'd1,	// Rn = imm
		ALU3   = 3'd2,	// Rn = Rs op Rt
		ALUCMP = 3'd3,	// T = Rs cmp Rt
		MUL3   = 3'd4,	// Rn = low half of Rs * Rt
		SLEEP  = 3'd5	// Stall for sleepCycles
	} opCodeT;

	// Sub-operation, issued on opIxt
	typedef enum logic [2:0] {
		ADD   = 3'd0,
		SUB   = 3'd1,
		AND   = 3'd2,
		OR    = 3'd3,
		XOR   = 3'd4,
		CMPEQ = 3'd5,	// T = (Rs == Rt)
		CMPGT = 3'd6	// T = (Rs > Rt), signed
	} aluIxtT;

	// Cycles EX2 holds for SLEEP
	localparam int sleepCycles = 4;

	// Hold counter must reach sleepCycles
	localparam int holdCntWidth = $clog2(sleepCycles + 1);

endpackage

`default_nettype wire

/* regPkg.sv */
`default_nettype none

package regPkg;

	// Register and result width
	localparam int dataWidth = 32;

	// General register count
	localparam int numRegs = 16;

	// Enough bits to name every register
	localparam int regIdWidth = $clog2(numRegs);

	// Hardwired zero, also the "no write" target in EX2
	localparam logic [regIdWidth-1:0] zeroReg = '0;

endpackage

`default_nettype wire

/* exRegFile.sv */
`timescale 1ns/1ps
`default_nettype none

module exRegFile import regPkg::*; (
	input  wire logic                  clock,
	input  wire logic                  arstN,
	input  wire logic [regIdWidth-1:0] rdIdA,
	input  wire logic [regIdWidth-1:0] rdIdB,
	input  wire logic                  wbValid,
	input  wire logic [regIdWidth-1:0] wbId,
	input  wire logic [dataWidth-1:0]  wbVal,
	input  wire logic                  srWe,
	input  wire logic                  srVal,
	output logic      [dataWidth-1:0]  rdValA,
	output logic      [dataWidth-1:0]  rdValB,
	output logic                       srT
);

	logic [dataWidth-1:0] regs [numRegs];	// General registers
	logic                 tBit;				// Status T

	// Async read, zero register hardwired
	assign rdValA = (rdIdA == zeroReg) ? '0 : regs[rdIdA];
	assign rdValB = (rdIdB == zeroReg) ? '0 : regs[rdIdB];
	assign srT    = tBit;

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < numRegs; i++) begin
				regs[i] <= '0;
			end
		end else if (wbValid && wbId != zeroReg) begin	// Drop writes to zero
			regs[wbId] <= wbVal;
		end
	end

	// T written straight from EX2, lands with wbValid
	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN)
			tBit <= 1'b0;
		else if (srWe)
			tBit <= srVal;
	end

endmodule

`default_nettype wire

/* exEx1.sv */
`timescale 1ns/1ps
`default_nettype none

module exEx1 import opPkg::*, regPkg::*; (
	input  wire logic                  clock,
	input  wire logic                  arstN,
	input  wire logic                  hold,
	input  wire opCodeT                opCmd,
	input  wire aluIxtT                opIxt,
	input  wire logic [regIdWidth-1:0] regIdRs,
	input  wire logic [regIdWidth-1:0] regIdRt,
	input  wire logic [regIdWidth-1:0] regIdRn,
	input  wire logic [dataWidth-1:0]  imm,
	input  wire logic                  kill,
	input  wire logic [dataWidth-1:0]  rdValA,
	input  wire logic [dataWidth-1:0]  rdValB,
	input  wire logic [regIdWidth-1:0] fwdIdEx2,
	input  wire logic [dataWidth-1:0]  fwdValEx2,
	input  wire logic                  fwdValidEx2,
	input  wire logic [regIdWidth-1:0] wbId,
	input  wire logic [dataWidth-1:0]  wbVal,
	input  wire logic                  wbValid,
	output logic      [regIdWidth-1:0] rdIdA,
	output logic      [regIdWidth-1:0] rdIdB,
	output opCodeT                     cmd1,
	output aluIxtT                     ixt1,
	output logic      [regIdWidth-1:0] idRn1,
	output logic      [dataWidth-1:0]  valRn1,
	output logic                       kill1,
	output logic      [dataWidth-1:0]  opA1,	// Forwarded operand, this cycle
	output logic      [dataWidth-1:0]  opB1
);

	// Newest value wins: EX2 in flight, then writeback, then RF
	function automatic logic [dataWidth-1:0] fwdOperand(
		input logic [regIdWidth-1:0] id,
		input logic [dataWidth-1:0]  rfVal
	);
		logic [dataWidth-1:0] val;
		val = rfVal;
		if (id != zeroReg) begin	// R0 is never forwarded
			if (fwdValidEx2 && fwdIdEx2 == id)
				val = fwdValEx2;
			else if (wbValid && wbId == id)
				val = wbVal;
		end
		return val;
	endfunction

	assign rdIdA = regIdRs;
	assign rdIdB = regIdRt;

	always_comb begin
		opA1 = fwdOperand(regIdRs, rdValA);
		opB1 = fwdOperand(regIdRt, rdValB);
	end

	// Issue register, frozen during hold
	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			cmd1  <= NOP;
			ixt1  <= ADD;
			idRn1 <= zeroReg;
			kill1 <= 1'b0;
		end else if (!hold) begin
			cmd1  <= opCmd;
			ixt1  <= opIxt;
			idRn1 <= regIdRn;
			kill1 <= kill;
		end
	end

	// Immediate rides to EX2 as the default result
	always_ff @(posedge clock) begin
		if (!hold)
			valRn1 <= (opCmd == MOV_IR) ? imm : '0;
	end

endmodule

`default_nettype wire

/* exAluUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module exAluUnit import opPkg::*, regPkg::*; (
	input  wire logic                 clock,
	input  wire logic                 arstN,
	input  wire logic                 hold,
	input  wire opCodeT               cmdIn,	// Issuing op, same cycle as opA/opB
	input  wire aluIxtT               ixtIn,
	input  wire logic [dataWidth-1:0] opA,
	input  wire logic [dataWidth-1:0] opB,
	output logic      [dataWidth-1:0] aluRes,
	output logic                      aluT,
	output logic      [dataWidth-1:0] mulRes
);

	logic [dataWidth-1:0] resNext;
	logic                 tNext;
	logic [dataWidth-1:0] mulLo;

	always_comb begin
		resNext = '0;
		tNext   = 1'b0;
		case (ixtIn)
			ADD:     resNext = opA + opB;
			SUB:     resNext = opA - opB;
			AND:     resNext = opA & opB;
			OR:      resNext = opA | opB;
			XOR:     resNext = opA ^ opB;
			CMPEQ:   tNext   = (opA == opB);
			CMPGT:   tNext   = ($signed(opA) > $signed(opB));	// Signed compare
			default: resNext = '0;
		endcase
	end

	assign mulLo = opA * opB;	// Truncates to the low word

	// Captured on the issue edge, lines up with the op in EX2
	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			aluRes <= '0;
			aluT   <= 1'b0;
			mulRes <= '0;
		end else if (!hold) begin
			if (cmdIn == ALU3 || cmdIn == ALUCMP) begin
				aluRes <= resNext;
				aluT   <= tNext;
			end
			if (cmdIn == MUL3)	// Multiplier only toggles for MUL3
				mulRes <= mulLo;
		end
	end

endmodule

`default_nettype wire

/* exEx2.sv */
`timescale 1ns/1ps
`default_nettype none

module exEx2 import opPkg::*, regPkg::*; (
	input  wire logic                  clock,
	input  wire logic                  arstN,
	input  wire opCodeT                cmd1,
	input  wire aluIxtT                ixt1,
	input  wire logic [regIdWidth-1:0] idRn1,
	input  wire logic [dataWidth-1:0]  valRn1,
	input  wire logic                  kill1,
	input  wire logic [dataWidth-1:0]  aluRes,
	input  wire logic                  aluT,
	input  wire logic [dataWidth-1:0]  mulRes,
	output logic                       hold,
	output logic                       wbValid,
	output logic      [regIdWidth-1:0] wbId,
	output logic      [dataWidth-1:0]  wbVal,
	output logic                       srWe,
	output logic                       srVal,
	output logic      [regIdWidth-1:0] fwdIdEx2,
	output logic      [dataWidth-1:0]  fwdValEx2,
	output logic                       fwdValidEx2
);

	logic [holdCntWidth-1:0] holdCnt;	// Cycles spent in hold so far
	logic [holdCntWidth-1:0] holdLen;	// Cycles this op wants

	always_comb begin
		fwdIdEx2  = idRn1;	// Pass EX1 result by default
		fwdValEx2 = valRn1;
		srWe      = 1'b0;
		srVal     = aluT;
		holdLen   = '0;
		case (cmd1)
			MOV_IR: ;	// Immediate already in valRn1
			ALU3: begin
				if (ixt1 == CMPEQ || ixt1 == CMPGT)
					fwdIdEx2 = zeroReg;	// Not an ALU3 sub-op
				else
					fwdValEx2 = aluRes;
			end
			ALUCMP: begin
				fwdIdEx2 = zeroReg;	// T only
				srWe     = (ixt1 == CMPEQ || ixt1 == CMPGT);
			end
			MUL3:  fwdValEx2 = mulRes;
			SLEEP: begin
				fwdIdEx2 = zeroReg;
				holdLen  = holdCntWidth'(sleepCycles);
			end
			default: fwdIdEx2 = zeroReg;	// NOP and unknown
		endcase
		if (kill1) begin	// Flushed: no write, no T, no stall
			fwdIdEx2 = zeroReg;
			srWe     = 1'b0;
			holdLen  = '0;
		end
		fwdValidEx2 = (fwdIdEx2 != zeroReg);
	end

	assign hold = (holdCnt < holdLen);

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			holdCnt <= '0;
			wbValid <= 1'b0;
		end else begin
			holdCnt <= hold ? holdCnt + 1'b1 : '0;	// Clears as hold drops
			wbValid <= fwdValidEx2;
		end
	end

	// Writeback stage register
	always_ff @(posedge clock) begin
		wbId  <= fwdIdEx2;
		wbVal <= fwdValEx2;
	end

endmodule

`default_nettype wire

/* exCore.sv */
`timescale 1ns/1ps
`default_nettype none

module exCore import opPkg::*, regPkg::*; (
	input  wire logic                  clock,
	input  wire logic                  arstN,
	input  wire opCodeT                opCmd,
	input  wire aluIxtT                opIxt,
	input  wire logic [regIdWidth-1:0] regIdRs,
	input  wire logic [regIdWidth-1:0] regIdRt,
	input  wire logic [regIdWidth-1:0] regIdRn,
	input  wire logic [dataWidth-1:0]  imm,
	input  wire logic                  kill,
	output logic                       hold,
	output logic                       wbValid,
	output logic      [regIdWidth-1:0] wbId,
	output logic      [dataWidth-1:0]  wbVal,
	output logic                       srT
);

	logic [regIdWidth-1:0] rdIdA, rdIdB;
	logic [dataWidth-1:0]  rdValA, rdValB;
	opCodeT                cmd1;
	aluIxtT                ixt1;
	logic [regIdWidth-1:0] idRn1;
	logic [dataWidth-1:0]  valRn1;
	logic                  kill1;
	logic [dataWidth-1:0]  opA1, opB1;	// Forwarded operands
	logic [dataWidth-1:0]  aluRes, mulRes;
	logic                  aluT;
	logic                  srWe, srVal;
	logic [regIdWidth-1:0] fwdIdEx2;
	logic [dataWidth-1:0]  fwdValEx2;
	logic                  fwdValidEx2;

	exRegFile regFile_i (.clock, .arstN, .rdIdA, .rdIdB, .wbValid, .wbId, .wbVal,
		.srWe, .srVal, .rdValA, .rdValB, .srT);

	exEx1 ex1_i (.clock, .arstN, .hold, .opCmd, .opIxt, .regIdRs, .regIdRt, .regIdRn,
		.imm, .kill, .rdValA, .rdValB, .fwdIdEx2, .fwdValEx2, .fwdValidEx2, .wbId,
		.wbVal, .wbValid, .rdIdA, .rdIdB, .cmd1, .ixt1, .idRn1, .valRn1, .kill1,
		.opA1, .opB1);

	// ALU sees the op as it issues
	exAluUnit alu_i (.clock, .arstN, .hold, .cmdIn(opCmd), .ixtIn(opIxt),
		.opA(opA1), .opB(opB1), .aluRes, .aluT, .mulRes);

	exEx2 ex2_i (.clock, .arstN, .cmd1, .ixt1, .idRn1, .valRn1, .kill1, .aluRes,
		.aluT, .mulRes, .hold, .wbValid, .wbId, .wbVal, .srWe, .srVal, .fwdIdEx2,
		.fwdValEx2, .fwdValidEx2);

endmodule

`default_nettype wire

/* exCoreTb.sv */
`timescale 1ns/1ps
`default_nettype none

module exCoreTb import opPkg::*, regPkg::*;;

	localparam int maxRows  = 64;
	localparam int holdLimit = sleepCycles + 8;	// Give up after this many hold cycles

	logic                  clock;
	logic                  arstN;
	opCodeT                opCmd;
	aluIxtT                opIxt;
	logic [regIdWidth-1:0] regIdRs, regIdRt, regIdRn;
	logic [dataWidth-1:0]  imm;
	logic                  kill;
	logic                  hold;
	logic                  wbValid;
	logic [regIdWidth-1:0] wbId;
	logic [dataWidth-1:0]  wbVal;
	logic                  srT;

	// Golden rows
	string                 rowName [maxRows];
	logic [2:0]            rowOp [maxRows];
	logic [2:0]            rowIxt [maxRows];
	logic [regIdWidth-1:0] rowRs [maxRows], rowRt [maxRows], rowRn [maxRows];
	logic [dataWidth-1:0]  rowImm [maxRows];
	logic                  rowKill [maxRows];
	logic                  expValid [maxRows];
	logic [regIdWidth-1:0] expId [maxRows];
	logic [dataWidth-1:0]  expVal [maxRows];
	logic                  expT [maxRows];
	int                    numRows;

	int testsRun;
	int testsBad;

	exCore exCore_i (.clock, .arstN, .opCmd, .opIxt, .regIdRs, .regIdRt, .regIdRn, .imm,
		.kill, .hold, .wbValid, .wbId, .wbVal, .srT);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;	// 8 ns period
	end

	// Rows with '#' in front are comments
	task automatic loadGolden();
		int    fd;
		int    got;
		string line;
		string name;
		logic [31:0] f [11];
		numRows = 0;
		fd = $fopen("exCoreGolden.txt", "r");
		if (fd == 0) begin
			$display("Cannot open exCoreGolden.txt");
		end else begin
			while (!$feof(fd) && numRows < maxRows) begin
				line = "";
				void'($fgets(line, fd));
				if (line.len() < 2 || line[0] == "#")
					continue;
				got = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h", name, f[0], f[1],
					f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10]);
				if (got != 12)
					continue;
				rowName[numRows]  = name;
				rowOp[numRows]    = f[0][2:0];
				rowIxt[numRows]   = f[1][2:0];
				rowRs[numRows]    = f[2][regIdWidth-1:0];
				rowRt[numRows]    = f[3][regIdWidth-1:0];
				rowRn[numRows]    = f[4][regIdWidth-1:0];
				rowImm[numRows]   = f[5];
				rowKill[numRows]  = f[6][0];
				expValid[numRows] = f[7][0];
				expId[numRows]    = f[8][regIdWidth-1:0];
				expVal[numRows]   = f[9];
				expT[numRows]     = f[10][0];
				numRows++;
			end
			$fclose(fd);
		end
	endtask

	// Put row idx on the inputs, or a bubble past the end
	task automatic driveRow(input int idx);
		if (idx < numRows) begin
			opCmd   = opCodeT'(rowOp[idx]);
			opIxt   = aluIxtT'(rowIxt[idx]);
			regIdRs = rowRs[idx];
			regIdRt = rowRt[idx];
			regIdRn = rowRn[idx];
			imm     = rowImm[idx];
			kill    = rowKill[idx];
		end else begin
			opCmd   = NOP;
			opIxt   = ADD;
			regIdRs = '0;
			regIdRt = '0;
			regIdRn = '0;
			imm     = '0;
			kill    = 1'b0;
		end
	endtask

	// Outputs of the op that just left EX2
	task automatic checkRow(input int idx, input int holdSeen);
		int errs;
		int wantHold;
		errs = 0;
		wantHold = (rowOp[idx] == 3'(SLEEP) && !rowKill[idx]) ? sleepCycles : 0;
		assert (wbValid === expValid[idx]) else begin
			$display("Fail %s wbValid expected %0h actual %0h", rowName[idx], expValid[idx],
				wbValid);
			errs++;
		end
		if (expValid[idx]) begin
			assert (wbId === expId[idx]) else begin
				$display("Fail %s wbId expected %0h actual %0h", rowName[idx], expId[idx], wbId);
				errs++;
			end
			assert (wbVal === expVal[idx]) else begin
				$display("Fail %s wbVal expected %h actual %h", rowName[idx], expVal[idx], wbVal);
				errs++;
			end
		end
		assert (srT === expT[idx]) else begin
			$display("Fail %s srT expected %0h actual %0h", rowName[idx], expT[idx], srT);
			errs++;
		end
		assert (holdSeen == wantHold) else begin	// Hold length counted here
			$display("Fail %s holdCycles expected %0d actual %0d", rowName[idx], wantHold,
				holdSeen);
			errs++;
		end
		testsRun++;
		if (errs == 0) begin
			$display("test %s ok", rowName[idx]);
		end else begin
			testsBad++;
			$display("test %s had %0d errors", rowName[idx], errs);
		end
	endtask

	initial begin
		int  nextIdx;
		int  ex2Idx;
		int  holdCnt;
		logic holdNow;
		logic timedOut;
		arstN     = 1'b0;
		testsRun  = 0;
		testsBad  = 0;
		timedOut  = 1'b0;
		driveRow(maxRows);
		loadGolden();
		repeat (2) @(posedge clock);	// Reset for 2 cycles
		@(negedge clock);
		arstN   = 1'b1;
		nextIdx = 0;
		ex2Idx  = -1;	// Nothing in EX2 yet
		holdCnt = 0;
		while (nextIdx < numRows || ex2Idx >= 0) begin
			driveRow(nextIdx);
			holdNow = hold;	// Stable at the falling edge
			@(posedge clock);
			@(negedge clock);
			if (holdNow) begin
				holdCnt++;
				if (holdCnt > holdLimit) begin
					$display("Timeout, hold stayed high for %0d cycles", holdCnt);
					timedOut = 1'b1;
					break;
				end
			end else begin
				if (ex2Idx >= 0)
					checkRow(ex2Idx, holdCnt);
				holdCnt = 0;
				ex2Idx  = (nextIdx < numRows) ? nextIdx : -1;
				nextIdx++;
			end
		end
		$display("tests run %0d, failing %0d", testsRun, testsBad);
		if (!timedOut && testsBad == 0 && testsRun == numRows && numRows > 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

`default_nettype wire

/* exCoreGolden.txt */
# name op ixt rs rt rn imm kill | expected wbValid wbId wbVal srT (hex)
# op: 0 NOP 1 MOV_IR 2 ALU3 3 ALUCMP 4 MUL3 5 SLEEP; ixt: 0 ADD 1 SUB 2 AND 3 OR 4 XOR 5 CMPEQ 6 CMPGT
movA       1 0 0 0 1 0000000c 0 1 1 0000000c 0
movB       1 0 0 0 2 00000005 0 1 2 00000005 0
movZero    1 0 0 0 0 00000077 0 0 0 00000000 0
add        2 0 1 2 3 00000000 0 1 3 00000011 0
sub        2 1 3 2 4 00000000 0 1 4 0000000c 0
and        2 2 4 1 5 00000000 0 1 5 0000000c 0
or         2 3 5 2 6 00000000 0 1 6 0000000d 0
xor        2 4 6 1 7 00000000 0 1 7 00000001 0
zeroRead   2 0 0 2 8 00000000 0 1 8 00000005 0
cmpEq      3 5 4 1 0 00000000 0 0 0 00000000 1
cmpGt      3 6 7 2 0 00000000 0 0 0 00000000 0
movNeg     1 0 0 0 9 ffffffff 0 1 9 ffffffff 0
cmpGtSign  3 6 2 9 0 00000000 0 0 0 00000000 1
mul        4 0 9 2 a 00000000 0 1 a fffffffb 1
mulSquare  4 0 a a b 00000000 0 1 b 00000019 1
killAdd    2 0 2 2 1 00000000 1 0 0 00000000 1
killCmp    3 6 7 2 0 00000000 1 0 0 00000000 1
afterKill  2 0 1 0 c 00000000 0 1 c 0000000c 1
sleep      5 0 0 0 0 00000000 0 0 0 00000000 1
afterSleep 2 0 c 2 d 00000000 0 1 d 00000011 1
killSleep  5 0 0 0 0 00000000 1 0 0 00000000 1
movLast    1 0 0 0 e 0000abcd 0 1 e 0000abcd 1

/* tb.f */
opPkg.sv
regPkg.sv
exRegFile.sv
exEx1.sv
exAluUnit.sv
exEx2.sv
exCore.sv
exCoreTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= exCoreTb
RTL_TOP   ?= exCore
FLIST     ?= tb.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD) -f $(FLIST)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -qx "all tests passed" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
